//--- bench/pktgen_sva.sv
module pktgen_sva
  import pktgen_pkg::*;
(
  input logic       gmii_tx_clk,
  input logic       sys_rst,
  input tx_state_t  state,
  input frame_len_t cur_len,
  input logic       gmii_tx_en,
  input byte_t      gmii_txd
);
  timeunit 1ns;
  timeprecision 1ps;

  logic        tx_en_d;
  logic [15:0] hi_cnt;  // Samples with gmii_tx_en high
  logic [15:0] len_q;

  always_ff @(posedge gmii_tx_clk) begin
    tx_en_d <= gmii_tx_en;
    if (sys_rst) begin
      hi_cnt <= '0;
    end else if (gmii_tx_en && !tx_en_d) begin
      hi_cnt <= 16'd1;
      len_q  <= cur_len;  // Length of the frame on the wire
    end else if (gmii_tx_en) begin
      hi_cnt <= hi_cnt + 16'd1;
    end
  end

  // Output register lags the state by one cycle
  no_tx_in_wait: assert property (@(posedge gmii_tx_clk) disable iff (sys_rst)
    state == tx_wait_arp |=> !gmii_tx_en)
    else $error("gmii_tx_en high while waiting for ARP reply");

  frame_length: assert property (@(posedge gmii_tx_clk) disable iff (sys_rst)
    (tx_en_d && !gmii_tx_en) |-> (hi_cnt == len_q + 16'd8))
    else $error("frame length on GMII differs from 8 + L");

  first_byte_preamble: assert property (@(posedge gmii_tx_clk) disable iff (sys_rst)
    (gmii_tx_en && !tx_en_d) |-> (gmii_txd == 8'h55))
    else $error("frame does not start with a preamble byte");

endmodule

bind frame_gen pktgen_sva u_sva (
  .gmii_tx_clk (gmii_tx_clk),
  .sys_rst     (sys_rst),
  .state       (state),
  .cur_len     (cur_len),
  .gmii_tx_en  (gmii_tx_en),
  .gmii_txd    (gmii_txd)
);

//--- bench/pktgen_tb.sv
`include "pktgen_params.svh"

module pktgen_tb
  import pktgen_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int tick = 4000;
  localparam int n_frames = 30;
  localparam longint wd_cycles = 16 + 3 * (8 + 64 + 4096) + n_frames * (8 + 200 + 20)
                                 + 3 * tick;
  localparam mac_addr_t gw_mac = 48'h001B21AABBCC;

  logic      gmii_tx_clk = 1'b0;
  logic      sys_rst;
  tx_cfg_t   cfg;
  byte_t     gmii_rxd;
  logic      gmii_rx_dv;
  byte_t     gmii_txd;
  logic      gmii_tx_en;
  mac_addr_t dst_mac;
  tx_stats_t stats;

  byte_t       frame_q[$];
  logic [31:0] seed = 32'd98369;
  time         rst_t = 0;
  int          arp_frames = 0;
  int          ipv4_frames = 0;
  int          last_seen = 0;    // IPv4 frames whose last byte went out
  int          low_cnt = 0;
  int          gap_before = 0;
  int          prev_kind = 0;    // 0 none, 1 ARP, 2 IPv4
  int          prev_gap = 0;
  int          start_len = 0;
  int          start_gap = 0;
  int          busy_windows = 0;
  bit          upd_req = 0;
  int          win_frames[64];
  int          win_bytes[64];

  pktgen_top #(.tick_cycles(tick)) dut (.*);

  always #20 gmii_tx_clk = ~gmii_tx_clk;

  // ----------------------------------------
  // Helpers and reference model
  // ----------------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("error %s: expected %0h, actual %0h", name, exp, act);
      fail_run("value mismatch");
    end
  endtask

  function automatic int next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return int'(seed[30:16]);
  endfunction

  function automatic logic [15:0] ipv4_csum(input int len, input logic [15:0] id);
    logic [31:0] s;
    s = 32'h4500 + 32'(16'(len - 18)) + 32'(id) + 32'h4011
        + cfg.src_ip[31:16] + cfg.src_ip[15:0] + cfg.gw_ip[31:16] + cfg.gw_ip[15:0];
    while (s[31:16] != 16'd0) begin
      s = {16'd0, s[15:0]} + {16'd0, s[31:16]};  // Fold carries
    end
    return ~s[15:0];
  endfunction

  // Expected byte k of a frame, counted from the first preamble byte
  function automatic byte_t expected_byte(input bit is_arp, input int k, input int len,
                                          input logic [15:0] id);
    logic [407:0] hdr;
    int n;
    int offs;
    if (k < 7) return 8'h55;
    if (k == 7) return 8'hD5;
    offs = k - 8;
    hdr = '0;
    if (is_arp) begin
      n = 42;
      hdr[335:0] = {48'hFFFFFFFFFFFF, cfg.src_mac, 16'h0806, 16'h0001, 16'h0800, 8'd6,
                    8'd4, 16'h0001, cfg.src_mac, cfg.src_ip, 48'h0, cfg.gw_ip};
    end else begin
      n = 51;
      hdr[407:0] = {gw_mac, cfg.src_mac, 16'h0800, 8'h45, 8'h00, 16'(len - 18), id,
                    16'h0000, 8'd64, 8'd17, ipv4_csum(len, id), cfg.src_ip, cfg.gw_ip,
                    16'd3422, 16'd3422, 16'(len - 38), 16'h0000, 40'hCC00CC00CC, 32'h0};
    end
    if (offs >= n) return 8'h00;  // Padding
    return hdr[8 * (n - 1 - offs) +: 8];
  endfunction

  function automatic logic [31:0] frame_crc(input int first, input int last);
    logic [31:0] c;
    c = 32'hFFFFFFFF;
    for (int i = first; i <= last; i++) begin
      c = c ^ {24'h0, frame_q[i]};
      for (int b = 0; b < 8; b++) begin
        c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
      end
    end
    return ~c;
  endfunction

  task automatic check_frame(input time t_end);
    bit          is_arp;
    int          len;
    int          w;
    logic [31:0] c;
    if (frame_q.size() < 30) fail_run("captured frame too short to classify");
    if ({frame_q[20], frame_q[21]} == 16'h0806) begin
      is_arp = 1'b1;
    end else if ({frame_q[20], frame_q[21]} == 16'h0800) begin
      is_arp = 1'b0;
    end else begin
      fail_run("captured frame has an unknown ethertype");
    end
    len = is_arp ? 64 : start_len;
    check(is_arp ? "arp length" : "ipv4 length", 8 + len, frame_q.size());
    for (int k = 0; k < 4 + len; k++) begin
      if (!is_arp && k >= 55 && k <= 58) continue;  // Timestamp comes from the DUT
      check($sformatf("%s byte %0d", is_arp ? "arp" : "ipv4", k),
            expected_byte(is_arp, k, len, 16'(ipv4_frames)), frame_q[k]);
    end
    c = frame_crc(8, 3 + len);
    for (int i = 0; i < 4; i++) begin
      check("fcs", c[8 * i +: 8], frame_q[4 + len + i]);  // LSB of the CRC first
    end
    if (is_arp) begin
      if (prev_kind == 1) check("arp retry gap", 4096, gap_before);
      arp_frames++;
      prev_kind = 1;
    end else begin
      if (prev_kind == 2) check("ipv4 gap", (prev_gap > 2) ? prev_gap : 2, gap_before);
      w = int'((t_end - rst_t - 40) / (tick * 40));
      win_frames[w] += 1;
      win_bytes[w] += len;
      ipv4_frames++;
      prev_kind = 2;
      prev_gap = start_gap;
    end
  endtask

  // ----------------------------------------
  // Frame capture and compare
  // ----------------------------------------
  always @(negedge gmii_tx_clk) begin
    if (sys_rst) begin
      low_cnt = 0;
    end else if (gmii_tx_en) begin
      if (frame_q.size() == 0) begin
        start_len = int'(cfg.frame_len);
        start_gap = int'(cfg.inter_frame_gap);
        gap_before = low_cnt;
      end
      frame_q.push_back(gmii_txd);
      if (frame_q.size() > 22 && {frame_q[20], frame_q[21]} == 16'h0800
          && frame_q.size() == 8 + start_len) begin
        last_seen++;
        upd_req = 1'b1;  // Next frame settings go in after this edge
      end
    end else if (frame_q.size() != 0) begin
      check_frame($time - 20);
      frame_q.delete();
      low_cnt = 1;
    end else begin
      low_cnt++;
    end
  end

  always @(posedge gmii_tx_clk) begin
    if (upd_req) begin
      upd_req = 1'b0;
      if (last_seen >= n_frames) begin
        cfg.enable <= 1'b0;
      end else begin
        cfg.frame_len       <= 16'(64 + next_rand() % 137);
        cfg.inter_frame_gap <= 32'(next_rand() % 21);
      end
    end
  end

  task automatic send_arp_reply(input ipv4_addr_t sender_ip, input mac_addr_t mac);
    logic [479:0] pkt;
    pkt = {cfg.src_mac, mac, 16'h0806, 16'h0001, 16'h0800, 8'd6, 8'd4, 16'h0002,
           mac, sender_ip, cfg.src_mac, cfg.src_ip, 144'h0};
    for (int i = 0; i < 60; i++) begin
      @(posedge gmii_tx_clk);
      gmii_rxd   <= pkt[8 * (59 - i) +: 8];
      gmii_rx_dv <= 1'b1;
    end
    @(posedge gmii_tx_clk);
    gmii_rx_dv <= 1'b0;
    gmii_rxd   <= 8'h00;
  endtask

  // Stats windows close one cycle after each sec_pulse
  initial begin : stats_monitor
    time target;
    wait (rst_t != 0);
    for (int k = 1; k < 64; k++) begin
      target = rst_t + (tick * k + 1) * 40 + 20;
      #(target - $time);
      check($sformatf("pps window %0d", k), win_frames[k - 1], stats.pps);
      check($sformatf("throughput window %0d", k), win_bytes[k - 1], stats.throughput);
      if (win_frames[k - 1] != 0) busy_windows++;
    end
  end

  initial begin : watchdog
    #(wd_cycles * 40);
    $display("Timeout: the test did not finish in %0d cycles", wd_cycles);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    sys_rst    = 1'b1;
    gmii_rxd   = 8'h00;
    gmii_rx_dv = 1'b0;
    cfg = '{enable: 1'b1, req_arp: 1'b0, frame_len: 16'd100, inter_frame_gap: 32'd5,
            src_mac: 48'h020000000001, src_ip: 32'hC0A80002, gw_ip: 32'hC0A80001};
    repeat (16) @(posedge gmii_tx_clk);
    sys_rst <= 1'b0;
    rst_t = $time;
    @(negedge gmii_tx_clk);
    check("tx_en after reset", 0, gmii_tx_en);
    check("dst_mac after reset", 0, dst_mac);
    check("stats after reset", 0, stats);

    wait (arp_frames >= 1);
    send_arp_reply(32'hC0A80063, gw_mac);  // Wrong sender IP
    @(negedge gmii_tx_clk);
    check("dst_mac after wrong reply", 0, dst_mac);

    wait (arp_frames >= 2);
    send_arp_reply(cfg.gw_ip, gw_mac);
    @(negedge gmii_tx_clk);
    check("dst_mac after reply", gw_mac, dst_mac);

    wait (ipv4_frames >= n_frames);
    repeat (2 * tick) @(posedge gmii_tx_clk);  // Enable is low from here on
    check("ipv4 frames with enable low", n_frames, ipv4_frames);
    check("arp frames", 2, arp_frames);
    if (busy_windows == 0) begin
      $display("No stats window with traffic was seen");
      $display("Simulation FAILED");
    end else begin
      $display("Simulation PASSED");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+hw
hw/pktgen_pkg.sv
hw/sec_tick.sv
hw/crc32_gen.sv
hw/arp_resolver.sv
hw/frame_gen.sv
hw/tx_rate_counter.sv
hw/pktgen_top.sv
bench/pktgen_sva.sv
bench/pktgen_tb.sv

//--- hw/arp_resolver.sv
`include "pktgen_params.svh"

module arp_resolver
  import pktgen_pkg::*;
(
  input  logic      gmii_tx_clk,
  input  logic      sys_rst,
  input  byte_t     gmii_rxd,
  input  logic      gmii_rx_dv,
  input  tx_cfg_t   cfg,
  output mac_addr_t dst_mac,
  output logic      arp_reply
);

  localparam logic [5:0] match_offset = 6'd42; // First byte after target IP

  logic [5:0]  rx_count;
  mac_addr_t   rx_src_mac;
  logic [15:0] rx_type;
  logic [15:0] rx_opcode;
  ipv4_addr_t  rx_sender_ip;
  ipv4_addr_t  rx_target_ip;
  logic        arp_match;

  // ----------------------------------------
  // Byte position within the frame
  // ----------------------------------------
  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      rx_count <= '0;
    end else if (!gmii_rx_dv) begin
      rx_count <= '0;                  // Idle between frames
    end else if (rx_count <= match_offset) begin
      rx_count <= rx_count + 6'd1;     // Parks past the match point
    end
  end

  // Header fields shift in most significant byte first
  always_ff @(posedge gmii_tx_clk) begin
    if (gmii_rx_dv) begin
      case (rx_count) inside
        [6:11]:  rx_src_mac   <= {rx_src_mac[39:0], gmii_rxd};
        [12:13]: rx_type      <= {rx_type[7:0], gmii_rxd};
        [20:21]: rx_opcode    <= {rx_opcode[7:0], gmii_rxd};
        [28:31]: rx_sender_ip <= {rx_sender_ip[23:0], gmii_rxd};
        [38:41]: rx_target_ip <= {rx_target_ip[23:0], gmii_rxd};
        default: ;
      endcase
    end
  end

  // ----------------------------------------
  // Reply check
  // ----------------------------------------
  assign arp_match = gmii_rx_dv && (rx_count == match_offset)
                     && (rx_type == `PKTGEN_ETHTYPE_ARP)
                     && (rx_opcode == `PKTGEN_ARP_OP_REPLY)
                     && (rx_sender_ip == cfg.gw_ip)   // From our gateway
                     && (rx_target_ip == cfg.src_ip)  // Addressed to us
                     && !rx_src_mac[40]               // Unicast sender
                     && !cfg.req_arp;

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      dst_mac   <= '0;
      arp_reply <= 1'b0;
    end else begin
      arp_reply <= arp_match;
      if (cfg.req_arp) begin
        dst_mac <= '0;                 // Drop the learned address
      end else if (arp_match) begin
        dst_mac <= rx_src_mac;
      end
    end
  end

endmodule

//--- hw/crc32_gen.sv
module crc32_gen
  import pktgen_pkg::*;
(
  input  logic   gmii_tx_clk,
  input  logic   sys_rst,
  input  logic   crc_init,
  input  logic   crc_en,
  input  byte_t  crc_data,
  output count_t crc
);

  localparam count_t crc_poly = 32'hEDB88320; // Reflected 802.3 polynomial
  localparam count_t crc_seed = 32'hFFFFFFFF;

  count_t crc_q;

  // One byte, LSB first
  function automatic count_t crc_step(input count_t c, input byte_t d);
    count_t r;
    r = c ^ {24'h0, d};
    for (int i = 0; i < 8; i++) begin
      r = r[0] ? ((r >> 1) ^ crc_poly) : (r >> 1);
    end
    return r;
  endfunction

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      crc_q <= crc_seed;
    end else if (crc_init) begin
      crc_q <= crc_seed;
    end else if (crc_en) begin
      crc_q <= crc_step(crc_q, crc_data);
    end
  end

  // Low register byte goes out first, so it lands in crc[31:24]
  assign crc = ~{crc_q[7:0], crc_q[15:8], crc_q[23:16], crc_q[31:24]};

endmodule

//--- hw/frame_gen.sv
`include "pktgen_params.svh"

module frame_gen
  import pktgen_pkg::*;
(
  input  logic      gmii_tx_clk,
  input  logic      sys_rst,
  input  tx_cfg_t   cfg,
  input  mac_addr_t dst_mac,
  input  logic      arp_reply,
  input  count_t    crc,
  output logic      crc_init,
  output logic      crc_en,
  output byte_t     crc_data,
  output byte_t     gmii_txd,
  output logic      gmii_tx_en,
  output logic      frame_done
);

  tx_state_t   state;
  frame_len_t  tx_count;      // Cycle within the frame, preamble included
  frame_len_t  frame_len_q;
  count_t      gap_q;
  count_t      wait_cnt;      // ARP timeout or gap length
  logic [15:0] ipv4_id;
  count_t      timestamp;
  count_t      ts_q;
  logic [19:0] ip_sum;
  logic [15:0] ip_fold;
  frame_len_t  cur_len;
  frame_len_t  offs;
  frame_len_t  fcs_start;
  frame_len_t  fcs_pos;
  frame_len_t  ip_len;
  frame_len_t  udp_len;
  count_t      gap_len;
  logic        sending;
  logic        last_byte;
  logic        start_ipv4;
  byte_t       next_byte;

  // Byte idx of an n_bytes wide field, most significant first
  function automatic byte_t field_byte(input logic [47:0] val, input int unsigned n_bytes,
                                       input int unsigned idx);
    return val[8*(n_bytes - 1 - idx) +: 8];
  endfunction

  assign sending   = (state == tx_req_arp) || (state == tx_ipv4_send);
  assign cur_len   = (state == tx_req_arp) ? `PKTGEN_ARP_FRAME_LEN : frame_len_q;
  assign offs      = tx_count - `PKTGEN_HDR_OFFSET;
  assign fcs_start = cur_len - 16'd4;
  assign fcs_pos   = offs - fcs_start;
  assign last_byte = (tx_count == cur_len + `PKTGEN_HDR_OFFSET - 16'd1);
  assign ip_len    = frame_len_q - 16'd18;  // Less Ethernet header and FCS
  assign udp_len   = frame_len_q - 16'd38;
  assign gap_len   = (gap_q > `PKTGEN_MIN_GAP) ? gap_q : `PKTGEN_MIN_GAP;
  assign ip_fold   = ip_sum[15:0] + {15'd0, ip_sum[16]};

  assign start_ipv4 = ((state == tx_wait_arp) && arp_reply)
                      || ((state == tx_gap) && (wait_cnt == '0) && cfg.enable
                          && (dst_mac != '0));

  // ----------------------------------------
  // Byte mux
  // ----------------------------------------
  always_comb begin
    next_byte = 8'h00;
    if (tx_count < `PKTGEN_HDR_OFFSET - 16'd1) begin
      next_byte = `PKTGEN_PREAMBLE_BYTE;
    end else if (tx_count == `PKTGEN_HDR_OFFSET - 16'd1) begin
      next_byte = `PKTGEN_SFD_BYTE;
    end else if (offs >= fcs_start) begin
      next_byte = field_byte(48'(crc), 4, fcs_pos[1:0]);
    end else if (state == tx_req_arp) begin
      case (offs) inside
        [0:5]:   next_byte = 8'hFF;                                  // Broadcast
        [6:11]:  next_byte = field_byte(cfg.src_mac, 6, offs - 6);
        [12:13]: next_byte = field_byte(48'(`PKTGEN_ETHTYPE_ARP), 2, offs - 12);
        [14:15]: next_byte = field_byte(48'h1, 2, offs - 14);        // HW type Ethernet
        [16:17]: next_byte = field_byte(48'(`PKTGEN_ETHTYPE_IPV4), 2, offs - 16);
        18:      next_byte = 8'd6;                                   // MAC length
        19:      next_byte = 8'd4;                                   // IP length
        [20:21]: next_byte = field_byte(48'(`PKTGEN_ARP_OP_REQUEST), 2, offs - 20);
        [22:27]: next_byte = field_byte(cfg.src_mac, 6, offs - 22);
        [28:31]: next_byte = field_byte(48'(cfg.src_ip), 4, offs - 28);
        [38:41]: next_byte = field_byte(48'(cfg.gw_ip), 4, offs - 38);
        default: next_byte = 8'h00;                                  // Target MAC, pad
      endcase
    end else begin
      case (offs) inside
        [0:5]:   next_byte = field_byte(dst_mac, 6, offs);
        [6:11]:  next_byte = field_byte(cfg.src_mac, 6, offs - 6);
        [12:13]: next_byte = field_byte(48'(`PKTGEN_ETHTYPE_IPV4), 2, offs - 12);
        14:      next_byte = 8'h45;                                  // Version, IHL
        [16:17]: next_byte = field_byte(48'(ip_len), 2, offs - 16);
        [18:19]: next_byte = field_byte(48'(ipv4_id), 2, offs - 18);
        22:      next_byte = `PKTGEN_IPV4_TTL;
        23:      next_byte = `PKTGEN_IPV4_PROTO_UDP;
        [24:25]: next_byte = field_byte(48'(ip_sum[15:0]), 2, offs - 24);
        [26:29]: next_byte = field_byte(48'(cfg.src_ip), 4, offs - 26);
        [30:33]: next_byte = field_byte(48'(cfg.gw_ip), 4, offs - 30);
        [34:37]: next_byte = field_byte(48'(`PKTGEN_UDP_PORT), 2, offs[0]); // Both ports
        [38:39]: next_byte = field_byte(48'(udp_len), 2, offs - 38);
        [42:46]: next_byte = field_byte(48'(`PKTGEN_MAGIC_CODE), 5, offs - 42);
        [47:50]: next_byte = field_byte(48'(ts_q), 4, offs - 47);
        default: next_byte = 8'h00;                                  // Zero fields, pad
      endcase
    end
  end

  assign crc_data = next_byte;
  assign crc_init = sending && (tx_count == '0);
  assign crc_en   = sending && (tx_count >= `PKTGEN_HDR_OFFSET) && (offs < fcs_start);

  // ----------------------------------------
  // Transmit FSM
  // ----------------------------------------
  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      state      <= tx_req_arp;
      tx_count   <= '0;
      wait_cnt   <= '0;
      ipv4_id    <= '0;
      timestamp  <= '0;
      frame_done <= 1'b0;
      gmii_tx_en <= 1'b0;
      gmii_txd   <= '0;
    end else begin
      timestamp  <= timestamp + 32'd1;
      frame_done <= 1'b0;
      gmii_tx_en <= sending;
      gmii_txd   <= sending ? next_byte : 8'h00;
      case (state)
        tx_req_arp: begin
          if (last_byte) begin
            tx_count <= '0;
            wait_cnt <= `PKTGEN_ARP_WAIT_CYCLES - 32'd1;
            state    <= tx_wait_arp;
          end else begin
            tx_count <= tx_count + 16'd1;
          end
        end
        tx_wait_arp: begin
          if (arp_reply) begin
            state <= tx_ipv4_send;
          end else if (wait_cnt == '0) begin
            state <= tx_req_arp;                   // Timed out, ask again
          end else begin
            wait_cnt <= wait_cnt - 32'd1;
          end
        end
        tx_ipv4_send: begin
          if (last_byte) begin
            tx_count   <= '0;
            wait_cnt   <= gap_len - 32'd1;
            ipv4_id    <= ipv4_id + 16'd1;
            frame_done <= 1'b1;
            state      <= tx_gap;
          end else begin
            tx_count <= tx_count + 16'd1;
          end
        end
        tx_gap: begin
          if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 32'd1;
          end else if (!cfg.enable) begin
            wait_cnt <= gap_len - 32'd1;           // Idle another gap
          end else if (dst_mac != '0) begin
            state <= tx_ipv4_send;
          end else begin
            state <= tx_req_arp;
          end
        end
        default: state <= tx_req_arp;
      endcase
    end
  end

  // Per-frame settings and header checksum, built over the preamble
  always_ff @(posedge gmii_tx_clk) begin
    if (start_ipv4) begin
      frame_len_q <= cfg.frame_len;
      gap_q       <= cfg.inter_frame_gap;
      ts_q        <= timestamp;                    // Send time
    end
    if (state == tx_ipv4_send) begin
      case (tx_count)
        16'd0: ip_sum <= 20'(16'h4500) + 20'(ip_len) + 20'(ipv4_id)
                         + 20'({`PKTGEN_IPV4_TTL, `PKTGEN_IPV4_PROTO_UDP})
                         + 20'(cfg.src_ip[31:16]) + 20'(cfg.src_ip[15:0])
                         + 20'(cfg.gw_ip[31:16]) + 20'(cfg.gw_ip[15:0]);
        16'd1: ip_sum <= 20'(ip_sum[15:0]) + 20'(ip_sum[19:16]);
        16'd2: ip_sum <= {4'h0, ~ip_fold};         // Final carry folded in
        default: ;
      endcase
    end
  end

endmodule

//--- hw/pktgen_params.svh
`ifndef PKTGEN_PARAMS_SVH
`define PKTGEN_PARAMS_SVH

// ----------------------------------------
// GMII framing
// ----------------------------------------
`define PKTGEN_PREAMBLE_BYTE 8'h55
`define PKTGEN_SFD_BYTE 8'hD5
`define PKTGEN_HDR_OFFSET 16'd8

// ----------------------------------------
// Protocol values
// ----------------------------------------
`define PKTGEN_ETHTYPE_IPV4 16'h0800
`define PKTGEN_ETHTYPE_ARP 16'h0806
`define PKTGEN_ARP_OP_REQUEST 16'd1
`define PKTGEN_ARP_OP_REPLY 16'd2
`define PKTGEN_IPV4_TTL 8'd64
`define PKTGEN_IPV4_PROTO_UDP 8'd17
`define PKTGEN_UDP_PORT 16'd3422
`define PKTGEN_MAGIC_CODE 40'hCC00CC00CC

// ----------------------------------------
// Lengths and timing
// ----------------------------------------
`define PKTGEN_ARP_FRAME_LEN 16'd64
`define PKTGEN_MIN_GAP 32'd2
`define PKTGEN_ARP_WAIT_CYCLES 32'd4096
`define PKTGEN_TICK_CYCLES 125000000

`endif

//--- hw/pktgen_pkg.sv
package pktgen_pkg;

  typedef logic [7:0]  byte_t;      // One GMII byte
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [15:0] frame_len_t; // Dest MAC through FCS
  typedef logic [31:0] count_t;     // Timestamp and stats

  // ----------------------------------------
  // Transmit FSM
  // ----------------------------------------
  typedef enum logic [1:0] {
    tx_req_arp,   // Broadcast ARP request
    tx_wait_arp,  // Wait for gateway reply
    tx_ipv4_send, // IPv4/UDP test frame
    tx_gap        // Inter-frame gap
  } tx_state_t;

  // ----------------------------------------
  // Configuration and statistics
  // ----------------------------------------
  typedef struct packed {
    logic       enable;
    logic       req_arp;         // Forces a new resolution
    frame_len_t frame_len;
    count_t     inter_frame_gap; // In clock cycles
    mac_addr_t  src_mac;
    ipv4_addr_t src_ip;
    ipv4_addr_t gw_ip;           // Also the IPv4 destination
  } tx_cfg_t;

  typedef struct packed {
    count_t pps;        // Frames in the last second
    count_t throughput; // Bytes in the last second
  } tx_stats_t;

endpackage

//--- hw/pktgen_top.sv
`include "pktgen_params.svh"

module pktgen_top
  import pktgen_pkg::*;
#(
  parameter int unsigned tick_cycles = `PKTGEN_TICK_CYCLES
) (
  input  logic      gmii_tx_clk,
  input  logic      sys_rst,
  input  tx_cfg_t   cfg,
  input  byte_t     gmii_rxd,
  input  logic      gmii_rx_dv,
  output byte_t     gmii_txd,
  output logic      gmii_tx_en,
  output mac_addr_t dst_mac,
  output tx_stats_t stats
);

  logic   sec_pulse;
  logic   arp_reply;
  logic   frame_done;
  logic   crc_init;
  logic   crc_en;
  byte_t  crc_data;
  count_t crc;

  sec_tick #(
    .period(tick_cycles)
  ) u_sec_tick (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .sec_pulse   (sec_pulse)
  );

  arp_resolver u_arp_resolver (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .gmii_rxd    (gmii_rxd),
    .gmii_rx_dv  (gmii_rx_dv),
    .cfg         (cfg),
    .dst_mac     (dst_mac),
    .arp_reply   (arp_reply)
  );

  frame_gen u_frame_gen (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .cfg         (cfg),
    .dst_mac     (dst_mac),
    .arp_reply   (arp_reply),
    .crc         (crc),
    .crc_init    (crc_init),
    .crc_en      (crc_en),
    .crc_data    (crc_data),
    .gmii_txd    (gmii_txd),
    .gmii_tx_en  (gmii_tx_en),
    .frame_done  (frame_done)
  );

  crc32_gen u_crc32_gen (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .crc_init    (crc_init),
    .crc_en      (crc_en),
    .crc_data    (crc_data),
    .crc         (crc)
  );

  tx_rate_counter u_tx_rate_counter (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .sec_pulse   (sec_pulse),
    .frame_done  (frame_done),
    .cfg         (cfg),
    .stats       (stats)
  );

endmodule

//--- hw/sec_tick.sv
module sec_tick #(
  parameter int unsigned period
) (
  input  logic gmii_tx_clk,
  input  logic sys_rst,
  output logic sec_pulse
);

  localparam int unsigned cnt_w = $clog2(period + 1);
  localparam logic [cnt_w-1:0] reload = cnt_w'(period - 1);

  logic [cnt_w-1:0] tick_cnt;

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      tick_cnt  <= reload;
      sec_pulse <= 1'b0;
    end else if (tick_cnt == '0) begin
      tick_cnt  <= reload;  // Period elapsed
      sec_pulse <= 1'b1;
    end else begin
      tick_cnt  <= tick_cnt - 1'b1;
      sec_pulse <= 1'b0;
    end
  end

endmodule

//--- hw/tx_rate_counter.sv
module tx_rate_counter
  import pktgen_pkg::*;
(
  input  logic      gmii_tx_clk,
  input  logic      sys_rst,
  input  logic      sec_pulse,
  input  logic      frame_done,
  input  tx_cfg_t   cfg,
  output tx_stats_t stats
);

  count_t frame_acc;
  count_t byte_acc;
  count_t frame_bytes;

  assign frame_bytes = count_t'(cfg.frame_len);

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      frame_acc <= '0;
      byte_acc  <= '0;
      stats     <= '0;
    end else if (sec_pulse) begin
      stats.pps        <= frame_acc;
      stats.throughput <= byte_acc;
      // A frame ending now opens the new window
      frame_acc <= frame_done ? 32'd1 : 32'd0;
      byte_acc  <= frame_done ? frame_bytes : 32'd0;
    end else if (frame_done) begin
      frame_acc <= frame_acc + 32'd1;
      byte_acc  <= byte_acc + frame_bytes;
    end
  end

endmodule
